// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = tcdm_group_tb
FILE_LIST = tcdm_group.f
BUILD_DIR = obj_dir
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tcdm_group.f ====
+incdir+verilog
verilog/tcdm_pkg.sv
verilog/tcdm_switch.sv
verilog/tcdm_bank.sv
verilog/tcdm_tile.sv
verilog/tcdm_group.sv
verif/tcdm_group_tb.sv

// ==== verif/tcdm_group_tb.sv ====
// ------------------------------
// TCDM group testbench
// Table-driven traffic checked against a byte-enable memory model
// ------------------------------

`timescale 1ns/100ps

`include "tcdm_group_consts.svh"

module tcdm_group_tb;

  localparam int N            = `TCDM_NUM_TILES;
  localparam int BANKS        = `TCDM_BANKS_PER_TILE;
  localparam int AW           = `TCDM_ADDR_WIDTH;
  localparam int DW           = `TCDM_DATA_WIDTH;
  localparam int BEW          = `TCDM_BE_WIDTH;
  localparam int BYTE_W       = DW / BEW;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_ENTRIES  = 62;
  localparam int NUM_PHASES   = 6;
  localparam int BP_PHASE     = 5;
  localparam logic [31:0] SEED    = 32'h8264b9fc;
  localparam logic [1:0]  CHK_LAT = 2'b01;
  localparam logic [1:0]  CHK_RDY = 2'b10;

  logic                   clk_i;
  logic                   rst_n_i;
  logic [N-1:0]           req_valid_i;
  logic [N-1:0]           req_ready_o;
  logic [N-1:0][AW-1:0]   req_addr_i;
  logic [N-1:0]           req_wen_i;
  logic [N-1:0][DW-1:0]   req_wdata_i;
  logic [N-1:0][BEW-1:0]  req_be_i;
  logic [N-1:0]           resp_valid_o;
  logic [N-1:0]           resp_ready_i;
  logic [N-1:0][DW-1:0]   resp_rdata_o;

  // Stimulus table, one column per array
  int            tbl_phase [NUM_ENTRIES];
  int            tbl_ini   [NUM_ENTRIES];
  logic          tbl_wen   [NUM_ENTRIES];
  logic [AW-1:0] tbl_addr  [NUM_ENTRIES];
  logic [DW-1:0] tbl_wdata [NUM_ENTRIES];
  logic [BEW-1:0] tbl_be   [NUM_ENTRIES];
  logic [1:0]    tbl_chk   [NUM_ENTRIES];
  logic [DW-1:0] tbl_exp   [NUM_ENTRIES];
  int            n_entries;

  logic [DW-1:0] model_mem [2**AW];
  int            reads_expected [N];
  int            resp_count [N];
  logic          held [N];
  logic [DW-1:0] held_data [N];
  logic          bp_on;
  logic [31:0]   bp_state;
  int            mismatch_count;
  int            failure_count;

  tcdm_group tcdm_group_i (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_addr_i  (req_addr_i  ),
    .req_wen_i   (req_wen_i   ),
    .req_wdata_i (req_wdata_i ),
    .req_be_i    (req_be_i    ),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_rdata_o(resp_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bank bits lowest, then tile, then row
  function automatic logic [AW-1:0] make_addr(input int tile, input int bank, input int row);
    return AW'((row * N + tile) * BANKS + bank);
  endfunction

  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_word,
                                               input logic [DW-1:0] new_word,
                                               input logic [BEW-1:0] be);
    logic [DW-1:0] w;
    w = old_word;
    for (int b = 0; b < BEW; b++) begin
      if (be[b]) begin
        w[b*BYTE_W +: BYTE_W] = new_word[b*BYTE_W +: BYTE_W];
      end
    end
    return w;
  endfunction

  task automatic report_mismatch(input string msg);
    mismatch_count++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    failure_count++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic add_entry(input int phase, input int ini, input logic wen,
                           input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
                           input logic [BEW-1:0] be, input logic [1:0] chk);
    if (n_entries < NUM_ENTRIES) begin
      tbl_phase[n_entries] = phase;
      tbl_ini[n_entries]   = ini;
      tbl_wen[n_entries]   = wen;
      tbl_addr[n_entries]  = addr;
      tbl_wdata[n_entries] = wdata;
      tbl_be[n_entries]    = be;
      tbl_chk[n_entries]   = chk;
    end
    n_entries++;
  endtask

  // ------------------------------
  // Table
  // ------------------------------

  task automatic build_table();
    logic [31:0] data_state;
    data_state = SEED;
    n_entries  = 0;
    // Full words in every tile and bank from one initiator
    for (int t = 0; t < N; t++) begin
      for (int b = 0; b < BANKS; b++) begin
        add_entry(0, 0, 1'b1, make_addr(t, b, 7*t + b + 1), DW'(32'hC0DE_0000 + t*256 + b),
                  '1, (t == 0 && b == 0) ? CHK_RDY : 2'b00);
      end
    end
    for (int t = 0; t < N; t++) begin
      for (int b = 0; b < BANKS; b++) begin
        add_entry(0, 0, 1'b0, make_addr(t, b, 7*t + b + 1), '0, '0, CHK_LAT);
      end
    end
    // Partial writes over earlier words
    add_entry(1, 1, 1'b1, make_addr(1, 0, 8), 32'h1122_3344, 4'b0101, 2'b00);
    add_entry(1, 1, 1'b1, make_addr(3, 1, 23), 32'hFF00_0000, 4'b1000, 2'b00);
    add_entry(1, 1, 1'b0, make_addr(1, 0, 8), '0, '0, 2'b00);
    add_entry(1, 1, 1'b0, make_addr(3, 1, 23), '0, '0, 2'b00);
    // Everyone into tile 2 at once
    for (int i = 0; i < N; i++) begin
      add_entry(2, i, 1'b1, make_addr(2, i % BANKS, 20 + i), DW'(32'h5A5A_0000 + i), '1, 2'b00);
      add_entry(2, i, 1'b0, make_addr(2, i % BANKS, 20 + i), '0, '0, 2'b00);
    end
    // Written by one initiator, read by another
    add_entry(3, 3, 1'b1, make_addr(0, 1, 33), 32'hBEEF_0003, '1, 2'b00);
    add_entry(4, 0, 1'b0, make_addr(0, 1, 33), '0, '0, 2'b00);
    // Random data under response back-pressure
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < 4; k++) begin
        data_state = next_random(data_state);
        add_entry(BP_PHASE, i, 1'b1, make_addr((i + k) % N, k % BANKS, 40 + 4*i + k),
                  data_state, '1, 2'b00);
      end
      for (int k = 0; k < 4; k++) begin
        add_entry(BP_PHASE, i, 1'b0, make_addr((i + k) % N, k % BANKS, 40 + 4*i + k),
                  '0, '0, 2'b00);
      end
    end
    assert (n_entries == NUM_ENTRIES)
      else report_failure($sformatf("table holds %0d entries, sized for %0d",
                                    n_entries, NUM_ENTRIES));
  endtask

  // Memory model walked in table order
  task automatic compute_expected();
    for (int i = 0; i < N; i++) begin
      reads_expected[i] = 0;
    end
    for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
      if (tbl_wen[idx]) begin
        model_mem[tbl_addr[idx]] = merge_bytes(model_mem[tbl_addr[idx]], tbl_wdata[idx],
                                               tbl_be[idx]);
      end else begin
        tbl_exp[idx] = model_mem[tbl_addr[idx]];
        reads_expected[tbl_ini[idx]]++;
      end
    end
  endtask

  // ------------------------------
  // Request drivers
  // ------------------------------

  task automatic run_entry(input int idx);
    int ini;
    int waited;
    int lat;
    int first_lat;
    ini = tbl_ini[idx];
    @(negedge clk_i);
    req_valid_i[ini] = 1'b1;
    req_addr_i[ini]  = tbl_addr[idx];
    req_wen_i[ini]   = tbl_wen[idx];
    req_wdata_i[ini] = tbl_wdata[idx];
    req_be_i[ini]    = tbl_be[idx];
    waited = 0;
    @(posedge clk_i);
    while (!req_ready_o[ini]) begin
      waited++;
      @(posedge clk_i);
    end
    if ((tbl_chk[idx] & CHK_RDY) != 0) begin
      assert (waited == 0)
        else report_failure($sformatf("lone request of initiator %0d waited %0d cycles",
                                      ini, waited));
    end
    @(negedge clk_i);
    req_valid_i[ini] = 1'b0;
    if (!tbl_wen[idx]) begin
      lat       = 0;
      first_lat = 0;
      do begin
        @(posedge clk_i);
        lat++;
        if (resp_valid_o[ini] && first_lat == 0) begin
          first_lat = lat;
        end
      end while (!(resp_valid_o[ini] && resp_ready_i[ini]));
      if ((tbl_chk[idx] & CHK_LAT) != 0) begin
        assert (first_lat == 3)
          else report_mismatch($sformatf("entry %0d: response after %0d cycles, expected 3",
                                         idx, first_lat));
      end
      assert (resp_rdata_o[ini] === tbl_exp[idx])
        else report_mismatch($sformatf("entry %0d ini %0d addr 0x%0h: read 0x%08h, expected 0x%08h",
                                       idx, ini, tbl_addr[idx], resp_rdata_o[ini], tbl_exp[idx]));
    end
  endtask

  task automatic run_initiator(input int phase, input int ini);
    for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
      if (tbl_phase[idx] == phase && tbl_ini[idx] == ini) begin
        run_entry(idx);
      end
    end
  endtask

  // Response back-pressure
  initial begin
    bp_state     = SEED;
    resp_ready_i = '1;
    forever begin
      @(negedge clk_i);
      if (bp_on) begin
        bp_state     = next_random(bp_state);
        resp_ready_i = bp_state[N-1:0];
      end else begin
        resp_ready_i = '1;
      end
    end
  end

  // Count responses, watch stalled data
  always @(posedge clk_i) begin
    for (int i = 0; i < N; i++) begin
      if (!rst_n_i) begin
        resp_count[i] = 0;
        held[i]       = 1'b0;
      end else begin
        if (held[i]) begin
          assert (resp_valid_o[i])
            else report_failure($sformatf("initiator %0d: response dropped while stalled", i));
          assert (resp_rdata_o[i] === held_data[i])
            else report_mismatch($sformatf("initiator %0d: stalled rdata 0x%08h became 0x%08h",
                                           i, held_data[i], resp_rdata_o[i]));
        end
        if (resp_valid_o[i] && resp_ready_i[i]) begin
          resp_count[i]++;
        end
        held[i]      = resp_valid_o[i] && !resp_ready_i[i];
        held_data[i] = resp_rdata_o[i];
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES + NUM_ENTRIES * 40) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", RESET_CYCLES + NUM_ENTRIES * 40);
    $display("Errors found");
    $finish;
  end

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    rst_n_i        = 1'b0;
    req_valid_i    = '0;
    req_addr_i     = '0;
    req_wen_i      = '0;
    req_wdata_i    = '0;
    req_be_i       = '0;
    bp_on          = 1'b0;
    mismatch_count = 0;
    failure_count  = 0;
    build_table();
    compute_expected();
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (2) begin
      @(posedge clk_i);
      assert (resp_valid_o == '0)
        else report_failure("response valid raised right after reset");
    end
    for (int p = 0; p < NUM_PHASES; p++) begin
      @(posedge clk_i);
      bp_on = (p == BP_PHASE);
      for (int i = 0; i < N; i++) begin
        automatic int ph  = p;
        automatic int ini = i;
        fork
          run_initiator(ph, ini);
        join_none
      end
      wait fork;
    end
    @(posedge clk_i);
    bp_on = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    for (int i = 0; i < N; i++) begin
      assert (resp_count[i] == reads_expected[i])
        else report_failure($sformatf("initiator %0d got %0d responses for %0d reads",
                                      i, resp_count[i], reads_expected[i]));
    end
    $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, failure_count);
    if (mismatch_count + failure_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verilog/tcdm_bank.sv ====
// ------------------------------
// TCDM bank
// Single-port word SRAM with byte-enable writes
// ------------------------------

`timescale 1ns/100ps

`include "tcdm_group_consts.svh"

module tcdm_bank (
  input  logic                        clk_i,
  input  logic                        en_i,
  input  logic                        wen_i,
  input  tcdm_pkg::row_t              row_i,
  input  logic [`TCDM_DATA_WIDTH-1:0] wdata_i,
  input  logic [`TCDM_BE_WIDTH-1:0]   be_i,
  output logic [`TCDM_DATA_WIDTH-1:0] rdata_o
);

  localparam int unsigned ByteWidth = `TCDM_DATA_WIDTH / `TCDM_BE_WIDTH;

  logic [`TCDM_DATA_WIDTH-1:0] mem_q [`TCDM_BANK_DEPTH];

  // Write merges enabled bytes
  always_ff @(posedge clk_i) begin
    if (en_i && wen_i) begin
      for (int unsigned b = 0; b < `TCDM_BE_WIDTH; b++) begin
        if (be_i[b]) begin
          mem_q[row_i][b*ByteWidth +: ByteWidth] <= wdata_i[b*ByteWidth +: ByteWidth];
        end
      end
    end
  end

  // Read data held until the next read
  always_ff @(posedge clk_i) begin
    if (en_i && !wen_i) begin
      rdata_o <= mem_q[row_i];
    end
  end

endmodule

// ==== verilog/tcdm_group.sv ====
// ------------------------------
// TCDM group
// Request and response switches around the banked tiles
// ------------------------------

`timescale 1ns/100ps

`include "tcdm_group_consts.svh"

module tcdm_group (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic [`TCDM_NUM_TILES-1:0]                       req_valid_i,
  output logic [`TCDM_NUM_TILES-1:0]                       req_ready_o,
  input  logic [`TCDM_NUM_TILES-1:0][`TCDM_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [`TCDM_NUM_TILES-1:0]                       req_wen_i,
  input  logic [`TCDM_NUM_TILES-1:0][`TCDM_DATA_WIDTH-1:0] req_wdata_i,
  input  logic [`TCDM_NUM_TILES-1:0][`TCDM_BE_WIDTH-1:0]   req_be_i,
  output logic [`TCDM_NUM_TILES-1:0]                       resp_valid_o,
  input  logic [`TCDM_NUM_TILES-1:0]                       resp_ready_i,
  output logic [`TCDM_NUM_TILES-1:0][`TCDM_DATA_WIDTH-1:0] resp_rdata_o
);

  tcdm_pkg::tile_idx_t  [`TCDM_NUM_TILES-1:0] ini_dst;
  tcdm_pkg::tcdm_req_t  [`TCDM_NUM_TILES-1:0] ini_req;
  logic                 [`TCDM_NUM_TILES-1:0] tile_req_valid;
  logic                 [`TCDM_NUM_TILES-1:0] tile_req_ready;
  tcdm_pkg::tcdm_req_t  [`TCDM_NUM_TILES-1:0] tile_req;
  logic                 [`TCDM_NUM_TILES-1:0] tile_resp_valid;
  logic                 [`TCDM_NUM_TILES-1:0] tile_resp_ready;
  tcdm_pkg::tcdm_resp_t [`TCDM_NUM_TILES-1:0] tile_resp;
  tcdm_pkg::tile_idx_t  [`TCDM_NUM_TILES-1:0] tile_resp_dst;
  tcdm_pkg::tcdm_resp_t [`TCDM_NUM_TILES-1:0] ini_resp;

  // ------------------------------
  // Address split
  // ------------------------------

  // Bank bits lowest, then tile, then row
  for (genvar i = 0; i < `TCDM_NUM_TILES; i++) begin : gen_ini
    assign ini_dst[i] = req_addr_i[i][`TCDM_BANK_BITS +: `TCDM_TILE_BITS];
    assign ini_req[i] = '{
      row:   req_addr_i[i][`TCDM_BANK_BITS + `TCDM_TILE_BITS +: `TCDM_ROW_BITS],
      bank:  req_addr_i[i][0 +: `TCDM_BANK_BITS],
      ini:   tcdm_pkg::tile_idx_t'(i),
      wen:   req_wen_i[i],
      wdata: req_wdata_i[i],
      be:    req_be_i[i]
    };
    assign resp_rdata_o[i] = ini_resp[i].rdata;
  end

  tcdm_switch #(
    .payload_t(tcdm_pkg::tcdm_req_t),
    .NumIn    (`TCDM_NUM_TILES     ),
    .NumOut   (`TCDM_NUM_TILES     )
  ) i_req_switch (
    .clk_i  (clk_i         ),
    .rst_n_i(rst_n_i       ),
    .valid_i(req_valid_i   ),
    .ready_o(req_ready_o   ),
    .dst_i  (ini_dst       ),
    .data_i (ini_req       ),
    .valid_o(tile_req_valid),
    .ready_i(tile_req_ready),
    .data_o (tile_req      )
  );

  // ------------------------------
  // Tiles
  // ------------------------------

  for (genvar t = 0; t < `TCDM_NUM_TILES; t++) begin : gen_tiles
    tcdm_tile i_tile (
      .clk_i       (clk_i             ),
      .rst_n_i     (rst_n_i           ),
      .req_valid_i (tile_req_valid[t] ),
      .req_ready_o (tile_req_ready[t] ),
      .req_i       (tile_req[t]       ),
      .resp_valid_o(tile_resp_valid[t]),
      .resp_ready_i(tile_resp_ready[t]),
      .resp_o      (tile_resp[t]      )
    );

    // Responses go home on the initiator index
    assign tile_resp_dst[t] = tile_resp[t].ini;
  end

  tcdm_switch #(
    .payload_t(tcdm_pkg::tcdm_resp_t),
    .NumIn    (`TCDM_NUM_TILES      ),
    .NumOut   (`TCDM_NUM_TILES      )
  ) i_resp_switch (
    .clk_i  (clk_i          ),
    .rst_n_i(rst_n_i        ),
    .valid_i(tile_resp_valid),
    .ready_o(tile_resp_ready),
    .dst_i  (tile_resp_dst  ),
    .data_i (tile_resp      ),
    .valid_o(resp_valid_o   ),
    .ready_i(resp_ready_i   ),
    .data_o (ini_resp       )
  );

endmodule

// ==== verilog/tcdm_group_consts.svh ====
// ------------------------------
// TCDM group geometry
// Sizes and widths of the shared scratchpad
// ------------------------------

`ifndef TCDM_GROUP_CONSTS_SVH
`define TCDM_GROUP_CONSTS_SVH

// One initiator port per tile
`define TCDM_NUM_TILES 4
`define TCDM_BANKS_PER_TILE 2

// Words per bank
`define TCDM_BANK_DEPTH 64

`define TCDM_DATA_WIDTH 32
`define TCDM_BE_WIDTH 4

// Word address, bank bits lowest, then tile bits, then row bits
`define TCDM_ADDR_WIDTH 9

`define TCDM_BANK_BITS $clog2(`TCDM_BANKS_PER_TILE)
`define TCDM_TILE_BITS $clog2(`TCDM_NUM_TILES)
`define TCDM_ROW_BITS $clog2(`TCDM_BANK_DEPTH)

`endif

// ==== verilog/tcdm_pkg.sv ====
// ------------------------------
// TCDM package
// Index, request and response types
// ------------------------------

`include "tcdm_group_consts.svh"

package tcdm_pkg;

  // Tile or initiator index
  typedef logic [`TCDM_TILE_BITS-1:0] tile_idx_t;

  // Bank within a tile
  typedef logic [`TCDM_BANK_BITS-1:0] bank_idx_t;

  // Word row within a bank
  typedef logic [`TCDM_ROW_BITS-1:0] row_t;

  // ------------------------------
  // Payloads
  // ------------------------------

  // Request after the tile bits are stripped off
  typedef struct packed {
    row_t                        row;
    bank_idx_t                   bank;
    tile_idx_t                   ini;
    logic                        wen;
    logic [`TCDM_DATA_WIDTH-1:0] wdata;
    logic [`TCDM_BE_WIDTH-1:0]   be;
  } tcdm_req_t;

  // Read response, routed back on ini
  typedef struct packed {
    tile_idx_t                   ini;
    logic [`TCDM_DATA_WIDTH-1:0] rdata;
  } tcdm_resp_t;

endpackage

// ==== verilog/tcdm_switch.sv ====
// ------------------------------
// TCDM switch
// N-to-N valid/ready switch, round-robin per output, registered outputs
// ------------------------------

`timescale 1ns/100ps

module tcdm_switch #(
  parameter type         payload_t = logic,
  parameter int unsigned NumIn     = 4,
  parameter int unsigned NumOut    = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                   [NumIn-1:0]  valid_i,
  output logic                   [NumIn-1:0]  ready_o,
  input  tcdm_pkg::tile_idx_t    [NumIn-1:0]  dst_i,
  input  payload_t               [NumIn-1:0]  data_i,
  output logic                   [NumOut-1:0] valid_o,
  input  logic                   [NumOut-1:0] ready_i,
  output payload_t               [NumOut-1:0] data_o
);

  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  typedef logic [IdxWidth-1:0] in_idx_t;

  in_idx_t  [NumOut-1:0]            rr_q;
  in_idx_t  [NumOut-1:0]            win_idx;
  logic     [NumOut-1:0]            win_found;
  logic     [NumOut-1:0]            out_free;
  logic     [NumOut-1:0][NumIn-1:0] grant;
  logic     [NumOut-1:0]            valid_q;
  payload_t [NumOut-1:0]            data_q;

  // Register empty or draining this cycle
  assign out_free = ~valid_q | ready_i;

  // ------------------------------
  // Arbitration
  // ------------------------------

  // Search starts one past the last winner
  always_comb begin
    int unsigned cand;
    cand      = 0;
    win_idx   = '0;
    win_found = '0;
    grant     = '0;
    for (int unsigned o = 0; o < NumOut; o++) begin
      for (int unsigned k = 1; k <= NumIn; k++) begin
        cand = (rr_q[o] + k) % NumIn;
        if (!win_found[o] && valid_i[cand] && (dst_i[cand] == o)) begin
          win_found[o] = 1'b1;
          win_idx[o]   = in_idx_t'(cand);
        end
      end
      if (win_found[o] && out_free[o]) begin
        grant[o][win_idx[o]] = 1'b1;
      end
    end
  end

  // Each input targets one output, so at most one grant per input
  always_comb begin
    ready_o = '0;
    for (int unsigned o = 0; o < NumOut; o++) begin
      ready_o = ready_o | grant[o];
    end
  end

  // ------------------------------
  // Output registers
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      for (int unsigned o = 0; o < NumOut; o++) begin
        rr_q[o] <= in_idx_t'(NumIn - 1);
      end
    end else begin
      for (int unsigned o = 0; o < NumOut; o++) begin
        if (out_free[o]) begin
          valid_q[o] <= win_found[o];
        end
        if (win_found[o] && out_free[o]) begin
          rr_q[o] <= win_idx[o];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned o = 0; o < NumOut; o++) begin
      if (win_found[o] && out_free[o]) begin
        data_q[o] <= data_i[win_idx[o]];
      end
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Destinations come from address bits or ini of the other side
  for (genvar i = 0; i < NumIn; i++) begin : gen_dst_check
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_i[i] |-> (dst_i[i] < NumOut))
      else $error("switch input %0d: destination out of range", i);
  end

  for (genvar o = 0; o < NumOut; o++) begin : gen_out_check
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (valid_o[o] && !ready_i[o]) |=> (valid_o[o] && $stable(data_o[o])))
      else $error("switch output %0d: dropped or changed while stalled", o);
  end

endmodule

// ==== verilog/tcdm_tile.sv ====
// ------------------------------
// TCDM tile
// Bank decode and read response hold
// ------------------------------

`timescale 1ns/100ps

`include "tcdm_group_consts.svh"

module tcdm_tile (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  tcdm_pkg::tcdm_req_t  req_i,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output tcdm_pkg::tcdm_resp_t resp_o
);

  logic                                                   req_fire;
  logic                                                   resp_valid_q;
  tcdm_pkg::bank_idx_t                                    bank_sel_q;
  tcdm_pkg::tile_idx_t                                    ini_q;
  logic [`TCDM_BANKS_PER_TILE-1:0][`TCDM_DATA_WIDTH-1:0] bank_rdata;

  // Accept only when the response slot is free or draining
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  // ------------------------------
  // Banks
  // ------------------------------

  for (genvar b = 0; b < `TCDM_BANKS_PER_TILE; b++) begin : gen_banks
    logic bank_en;

    assign bank_en = req_fire && (req_i.bank == tcdm_pkg::bank_idx_t'(b));

    tcdm_bank i_bank (
      .clk_i  (clk_i        ),
      .en_i   (bank_en      ),
      .wen_i  (req_i.wen    ),
      .row_i  (req_i.row    ),
      .wdata_i(req_i.wdata  ),
      .be_i   (req_i.be     ),
      .rdata_o(bank_rdata[b])
    );
  end

  // ------------------------------
  // Response
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      // Writes complete silently
      resp_valid_q <= !req_i.wen;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Remember where the read data will show up
  always_ff @(posedge clk_i) begin
    if (req_fire && !req_i.wen) begin
      bank_sel_q <= req_i.bank;
      ini_q      <= req_i.ini;
    end
  end

  // Bank output stays put while stalled, no new access is accepted
  assign resp_valid_o = resp_valid_q;
  assign resp_o       = '{ini: ini_q, rdata: bank_rdata[bank_sel_q]};

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_o)))
    else $error("tile: response dropped or changed while stalled");

endmodule
